//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Byte address of an instruction or a fetch word.
  typedef logic [31:0] addr_t;

  // One word as returned by instruction memory.
  typedef logic [31:0] word_t;

  // One 16-bit instruction parcel.
  typedef logic [15:0] half_t;

  // Assembled instruction, compressed ones zero extended.
  typedef logic [31:0] instr_t;

  // APB requester states.
  typedef enum logic [1:0] {
    apb_idle,
    apb_setup,
    apb_access
  } apb_state_t;

  // addi x0, x0, 0.
  localparam instr_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

//--- hdl/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc
  import fetch_pkg::*;
#(
  parameter addr_t reset_pc = 32'h0000_0000
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  redirect,
  input  addr_t redirect_pc,
  input  logic  stall,
  input  logic  accept,
  output logic  issue,
  output addr_t fetch_addr
);

  addr_t next_addr;
  logic  armed;

  // Word address of the next fetch.
  always_ff @(posedge clock) begin
    if (!reset) begin
      next_addr <= {reset_pc[31:2], 2'b00};
    end else if (redirect) begin
      next_addr <= {redirect_pc[31:2], 2'b00};
    end else if (accept) begin
      next_addr <= next_addr + 32'd4;
    end
  end

  // Requests start once reset has been released.
  always_ff @(posedge clock) begin
    if (!reset) begin
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
    end
  end

  // The requester takes a request only when it is idle,
  // so one transfer at most is ever in flight.
  assign issue = armed && !stall;

  assign fetch_addr = next_addr;

endmodule

`default_nettype wire

//--- hdl/fetch_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_apb_master
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  redirect,
  input  logic  issue,
  input  addr_t fetch_addr,
  output logic  accept,
  output addr_t paddr,
  output logic  psel,
  output logic  penable,
  output logic  pwrite,
  input  word_t prdata,
  input  logic  pready,
  input  logic  pslverr,
  output logic  ready,
  output word_t word,
  output addr_t word_addr,
  output logic  word_error
);

  apb_state_t state_q;
  apb_state_t state_n;
  addr_t      addr_q;
  word_t      data_q;
  logic       error_q;
  logic       ready_q;
  logic       stale_q;
  logic       done;

  assign done = (state_q == apb_access) && pready;

  always_comb begin
    state_n = state_q;
    case (state_q)
      apb_idle: begin
        // A redirect restarts fetch even while stalled.
        if (issue || redirect) begin
          state_n = apb_setup;
        end
      end
      apb_setup: begin
        state_n = apb_access;
      end
      apb_access: begin
        if (pready) begin
          state_n = apb_idle;
        end
      end
      default: begin
        state_n = apb_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= apb_idle;
      ready_q <= 1'b0;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_n;
      ready_q <= done && !stale_q && !redirect;
      if (done) begin
        stale_q <= 1'b0;
      end else if (redirect && state_q != apb_idle) begin
        stale_q <= 1'b1;
      end
    end
  end

  // Address is frozen at the end of setup.
  always_ff @(posedge clock) begin
    if (state_q == apb_setup) begin
      addr_q <= fetch_addr;
    end
    if (done) begin
      data_q  <= prdata;
      error_q <= pslverr;
    end
  end

  assign psel    = state_q != apb_idle;
  assign penable = state_q == apb_access;
  assign pwrite  = 1'b0;
  assign paddr   = (state_q == apb_setup) ? fetch_addr : addr_q;
  assign accept  = state_q == apb_setup;

  assign ready      = ready_q;
  assign word       = data_q;
  assign word_addr  = addr_q;
  assign word_error = error_q;

endmodule

`default_nettype wire

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer
  import fetch_pkg::*;
#(
  parameter int    buffer_depth = 8,
  parameter addr_t reset_pc     = 32'h0000_0000
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   redirect,
  input  addr_t  redirect_pc,
  input  logic   ready,
  input  word_t  word,
  input  addr_t  word_addr,
  input  logic   word_error,
  input  logic   hold,
  output logic   stall,
  output logic   valid,
  output addr_t  pc,
  output instr_t instr,
  output logic   compressed,
  output logic   error
);

  localparam int ptr_width = $clog2(buffer_depth);

  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [ptr_width:0]   count_t;

  localparam count_t stall_level = count_t'(buffer_depth / 2);

  half_t parcel_mem [buffer_depth];
  addr_t addr_mem [buffer_depth];
  logic [buffer_depth-1:0] error_mem;

  ptr_t   wid_q;
  ptr_t   rid_q;
  count_t count_q;
  logic   skip_q;

  ptr_t   wid_n;
  ptr_t   rid_n;
  count_t count_n;
  logic   skip_n;
  ptr_t   wid_hi;
  logic   write_en;

  ptr_t   slot_idx [2];
  half_t  slot_parcel [2];
  addr_t  slot_addr [2];
  logic [1:0] slot_error;

  logic   head_compressed;
  logic [1:0] take;
  count_t count_left;

  assign write_en = ready && !redirect;
  assign wid_hi   = wid_q + ptr_t'(1);

  // Pointer update for flush and arriving words.
  always_comb begin
    wid_n   = wid_q;
    rid_n   = rid_q;
    count_n = count_q;
    skip_n  = skip_q;
    if (redirect) begin
      wid_n   = '0;
      rid_n   = '0;
      count_n = '0;
      skip_n  = redirect_pc[1];
    end else if (ready) begin
      wid_n = wid_q + ptr_t'(2);
      if (skip_q) begin
        // Target sits in the upper half of the first word.
        rid_n   = rid_q + ptr_t'(1);
        count_n = count_q + count_t'(1);
        skip_n  = 1'b0;
      end else begin
        count_n = count_q + count_t'(2);
      end
    end
  end

  // Head and next entry, with bypass of the word being written.
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      slot_idx[s]    = rid_n + ptr_t'(s);
      slot_parcel[s] = parcel_mem[slot_idx[s]];
      slot_addr[s]   = addr_mem[slot_idx[s]];
      slot_error[s]  = error_mem[slot_idx[s]];
      if (write_en && slot_idx[s] == wid_q) begin
        slot_parcel[s] = word[15:0];
        slot_addr[s]   = {word_addr[31:2], 2'b00};
        slot_error[s]  = word_error;
      end else if (write_en && slot_idx[s] == wid_hi) begin
        slot_parcel[s] = word[31:16];
        slot_addr[s]   = {word_addr[31:2], 2'b10};
        slot_error[s]  = word_error;
      end
    end
  end

  always_comb begin
    head_compressed = slot_parcel[0][1:0] != 2'b11;
    take = 2'd0;
    if (!hold) begin
      if (head_compressed && count_n >= count_t'(1)) begin
        take = 2'd1;
      end else if (!head_compressed && count_n >= count_t'(2)) begin
        take = 2'd2;
      end
    end
  end

  assign count_left = count_n - count_t'(take);

  assign stall      = count_left > stall_level;
  assign valid      = take != 2'd0;
  assign pc         = valid ? slot_addr[0] : '0;
  assign compressed = valid && head_compressed;
  assign error      = valid && (slot_error[0] || (!head_compressed && slot_error[1]));

  always_comb begin
    if (!valid) begin
      instr = nop_instr;
    end else if (head_compressed) begin
      instr = {16'h0000, slot_parcel[0]};
    end else begin
      instr = {slot_parcel[1], slot_parcel[0]};
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wid_q   <= '0;
      rid_q   <= '0;
      count_q <= '0;
      skip_q  <= reset_pc[1];
    end else begin
      wid_q   <= wid_n;
      rid_q   <= rid_n + ptr_t'(take);
      count_q <= count_left;
      skip_q  <= skip_n;
    end
  end

  // Two parcels per word.
  always_ff @(posedge clock) begin
    if (write_en) begin
      parcel_mem[wid_q]  <= word[15:0];
      addr_mem[wid_q]    <= {word_addr[31:2], 2'b00};
      error_mem[wid_q]   <= word_error;
      parcel_mem[wid_hi] <= word[31:16];
      addr_mem[wid_hi]   <= {word_addr[31:2], 2'b10};
      error_mem[wid_hi]  <= word_error;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
#(
  parameter int    buffer_depth = 8,
  parameter addr_t reset_pc     = 32'h0000_0000
) (
  input  logic   clock,
  input  logic   reset,
  // Core side.
  input  logic   redirect,
  input  addr_t  redirect_pc,
  input  logic   hold,
  output logic   valid,
  output addr_t  pc,
  output instr_t instr,
  output logic   compressed,
  output logic   error,
  // Instruction memory, APB.
  output addr_t  paddr,
  output logic   psel,
  output logic   penable,
  output logic   pwrite,
  input  word_t  prdata,
  input  logic   pready,
  input  logic   pslverr
);

  logic  issue;
  addr_t fetch_addr;
  logic  accept;
  logic  stall;
  logic  ready;
  word_t word;
  addr_t word_addr;
  logic  word_error;

  fetch_pc #(
    .reset_pc    (reset_pc)
  ) fetch_pc_inst (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .stall       (stall),
    .accept      (accept),
    .issue       (issue),
    .fetch_addr  (fetch_addr)
  );

  fetch_apb_master fetch_apb_master_inst (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .issue       (issue),
    .fetch_addr  (fetch_addr),
    .accept      (accept),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .ready       (ready),
    .word        (word),
    .word_addr   (word_addr),
    .word_error  (word_error)
  );

  fetch_buffer #(
    .buffer_depth (buffer_depth),
    .reset_pc     (reset_pc)
  ) fetch_buffer_inst (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .ready        (ready),
    .word         (word),
    .word_addr    (word_addr),
    .word_error   (word_error),
    .hold         (hold),
    .stall        (stall),
    .valid        (valid),
    .pc           (pc),
    .instr        (instr),
    .compressed   (compressed),
    .error        (error)
  );

endmodule

`default_nettype wire

//--- tests/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb
  import fetch_pkg::*;
;

  localparam int    depth    = 8;
  localparam addr_t start_pc = 32'h0000_0102;

  // Canonical RV32 nop, addi x0, x0, 0.
  localparam instr_t rv32_nop = 32'h0000_0013;

  logic   clock;
  logic   reset;
  logic   redirect;
  addr_t  redirect_pc;
  logic   hold;
  logic   valid;
  addr_t  pc;
  instr_t instr;
  logic   compressed;
  logic   error;
  addr_t  paddr;
  logic   psel;
  logic   penable;
  logic   pwrite;
  word_t  prdata;
  logic   pready;
  logic   pslverr;

  // A 1 KB memory image indexed by address bits 9:2.
  word_t mem [256];
  addr_t err_addr;
  addr_t exp_pc;
  logic [31:0] lcg_state;
  int    wait_left;

  fetch_unit #(
    .buffer_depth (depth),
    .reset_pc     (start_pc)
  ) fetch_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .hold        (hold),
    .valid       (valid),
    .pc          (pc),
    .instr       (instr),
    .compressed  (compressed),
    .error       (error),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Words 64 to 127 hold only full instructions.
  function automatic word_t fill_word(int i);
    word_t h;
    h = word_t'(i) * 32'h9e37_79b1;
    h = h ^ (h >> 15) ^ (word_t'(i) << 7);
    if (i >= 64 && i < 128) begin
      h = h | 32'h0003_0003;
    end
    return h;
  endfunction

  function automatic half_t parcel_at(addr_t a);
    word_t w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic word_bad(addr_t a);
    return {a[31:2], 2'b00} == err_addr;
  endfunction

  // APB completer with 0 to 3 wait states.
  always @(posedge clock) begin
    if (psel && !penable) begin
      wait_left <= int'((lcg_next() >> 16) % 32'd4);
      pready    <= 1'b0;
      if (((lcg_state >> 16) % 32'd4) == 32'd0) begin
        pready  <= 1'b1;
        prdata  <= mem[paddr[9:2]];
        pslverr <= word_bad(paddr);
      end
    end else if (psel && penable && !pready) begin
      if (wait_left <= 1) begin
        pready  <= 1'b1;
        prdata  <= mem[paddr[9:2]];
        pslverr <= word_bad(paddr);
      end else begin
        wait_left <= wait_left - 1;
      end
    end else begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end
  end

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_instr(string name, instr_t got, instr_t exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(string what);
    $display("Timed out waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // Compares the instruction on the outputs with the memory walk.
  task automatic check_current();
    half_t  lo;
    half_t  hi;
    logic   comp;
    instr_t exp_instr;
    logic   exp_err;
    lo = parcel_at(exp_pc);
    hi = parcel_at(exp_pc + 32'd2);
    comp = lo[1:0] != 2'b11;
    exp_instr = comp ? {16'h0000, lo} : {hi, lo};
    exp_err = word_bad(exp_pc) || (!comp && word_bad(exp_pc + 32'd2));
    check_addr("pc", pc, exp_pc);
    check_instr("instr", instr, exp_instr);
    check_bit("compressed", compressed, comp);
    check_bit("error", error, exp_err);
    exp_pc = exp_pc + (comp ? 32'd2 : 32'd4);
  endtask

  task automatic check_next(int count);
    int cycles;
    for (int n = 0; n < count; n++) begin
      cycles = 0;
      @(negedge clock);
      while (!valid) begin
        cycles++;
        if (cycles > 100) begin
          fail_timeout("valid");
        end
        @(negedge clock);
      end
      check_current();
    end
  endtask

  task automatic redirect_to(addr_t target);
    @(posedge clock);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect    <= 1'b0;
    exp_pc = target;
  endtask

  task automatic reset_and_first_fetch();
    int cycles;
    repeat (16) begin
      @(negedge clock);
      check_bit("psel", psel, 1'b0);
      check_bit("penable", penable, 1'b0);
      check_bit("valid", valid, 1'b0);
    end
    @(posedge clock);
    reset <= 1'b1;
    cycles = 0;
    @(negedge clock);
    while (!psel) begin
      cycles++;
      if (cycles > 20) begin
        fail_timeout("the first APB setup");
      end
      @(negedge clock);
    end
    check_addr("paddr", paddr, {start_pc[31:2], 2'b00});
    check_bit("pwrite", pwrite, 1'b0);
    exp_pc = start_pc;
  endtask

  // Redirect lands in the access phase of a transfer.
  task automatic redirect_mid_transfer(addr_t target);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!(psel && !penable)) begin
      if (valid) begin
        check_current();
      end
      cycles++;
      if (cycles > 50) begin
        fail_timeout("an APB setup phase");
      end
      @(negedge clock);
    end
    if (valid) begin
      check_current();
    end
    redirect_to(target);
    check_next(16);
  endtask

  task automatic hold_and_release();
    check_next(2);
    @(posedge clock);
    hold <= 1'b1;
    repeat (60) begin
      @(negedge clock);
      check_bit("valid", valid, 1'b0);
      check_instr("instr", instr, rv32_nop);
      check_addr("pc", pc, 32'h0000_0000);
    end
    // Buffer is full by now, so the bus stays quiet.
    repeat (10) begin
      @(negedge clock);
      check_bit("valid", valid, 1'b0);
      check_bit("psel", psel, 1'b0);
    end
    @(posedge clock);
    hold <= 1'b0;
    check_next(20);
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    hold        = 1'b0;
    prdata      = '0;
    pready      = 1'b0;
    pslverr     = 1'b0;
    wait_left   = 0;
    lcg_state   = 32'd32;
    err_addr    = 32'hffff_fffc;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
    end

    reset_and_first_fetch();
    check_next(12);
    redirect_to(32'h0000_0200);
    check_next(24);
    redirect_mid_transfer(32'h0000_028a);
    hold_and_release();
    err_addr = 32'h0000_0300;
    redirect_to(32'h0000_02fa);
    check_next(12);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
hdl/fetch_pkg.sv
hdl/fetch_pc.sv
hdl/fetch_apb_master.sv
hdl/fetch_buffer.sv
hdl/fetch_unit.sv
tests/fetch_unit_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f fetch_unit.f --top-module fetch_unit_tb -o fetch_unit_tb
	./obj_dir/fetch_unit_tb | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
